/* periph_macros.svh */
// Shared address map, widths and reset values for the APB peripheral subsystem
// Offsets are byte addresses inside each 4 KiB region, word aligned only
`ifndef PERIPH_MACROS_SVH
`define PERIPH_MACROS_SVH

// APB bus widths
`define APB_ADDR_WIDTH   32
`define APB_DATA_WIDTH   32

// Address split into slave index and register offset
`define NUM_SLAVES       4
`define SLAVE_IDX_WIDTH  2
// Slave index sits directly above the offset field
`define REG_OFFSET_WIDTH 12

// Peripheral sizes
`define GPIO_WIDTH       32
`define NUM_IRQ          32

// Boot address after reset
`define ROM_START_ADDR   32'h8000

// Slave index of each peripheral
`define SLAVE_GPIO       0
`define SLAVE_TIMER      1
`define SLAVE_EVENT      2
`define SLAVE_SOC        3

// GPIO registers
`define GPIO_REG_DIR       12'h000
`define GPIO_REG_IN        12'h004
`define GPIO_REG_OUT       12'h008
`define GPIO_REG_INTEN     12'h00C
`define GPIO_REG_INTSTATUS 12'h010

// Timer registers
`define TIMER_REG_CTRL     12'h000
`define TIMER_REG_COUNT    12'h004
`define TIMER_REG_CMP      12'h008

// Event unit registers
`define EVENT_REG_IER      12'h000
`define EVENT_REG_IPR      12'h004
`define EVENT_REG_ICP      12'h008

// SoC control registers
`define SOC_REG_PADMUX     12'h000
`define SOC_REG_BOOTADR    12'h004

`endif

/* apb_pkg.sv */
// APB transfer types without PREADY, every access finishes in its access phase
// The address union assumes the slave index sits right above the offset
`include "periph_macros.svh"

package apb_pkg;

  // One bus data word
  typedef logic [`APB_DATA_WIDTH-1:0] apb_data_t;

  // Address seen as slave index plus register offset
  typedef struct packed {
    // Upper bits are not decoded, regions alias
    logic [`APB_ADDR_WIDTH-`SLAVE_IDX_WIDTH-`REG_OFFSET_WIDTH-1:0] upper;
    logic [`SLAVE_IDX_WIDTH-1:0]                                   slave_idx;
    logic [`REG_OFFSET_WIDTH-1:0]                                  offset;
  } apb_addr_fields_t;

  // Same 32 bits, raw word or decoded fields
  typedef union packed {
    logic [`APB_ADDR_WIDTH-1:0] word;
    apb_addr_fields_t           fields;
  } apb_addr_u;

  // Master to slave
  typedef struct packed {
    apb_addr_u paddr;
    apb_data_t pwdata;
    logic      pwrite;
    logic      psel;
    logic      penable;
  } apb_req_t;

  // Slave to master, valid in the access cycle
  typedef struct packed {
    apb_data_t prdata;
    logic      pslverr;
  } apb_resp_t;

endpackage

/* periph_pkg.sv */
// Interrupt and GPIO types shared by the peripherals
// Interrupt vector keeps the legacy bit positions, unused bits must stay zero
`include "periph_macros.svh"

package periph_pkg;

  // One bit per GPIO pin
  typedef logic [`GPIO_WIDTH-1:0] gpio_word_t;

  // Interrupt vector layout seen by the core
  typedef struct packed {
    // Bits 31:28, only bit 28 has a source
    logic [3:0]            timer_evt;
    // Bits 27:26
    logic [1:0]            rsvd_27_26;
    // Bit 25
    logic                  gpio_evt;
    // Bits 24:23
    logic [1:0]            rsvd_24_23;
    // Bit 22, redundancy alert
    logic                  alert_evt;
    // Bits 21:0
    logic [`NUM_IRQ-11:0]  rsvd_low;
  } irq_vec_t;

  // Raw event sources into the event unit
  typedef struct packed {
    // Compare match, single-cycle pulse
    logic timer;
    // OR of GPIO status bits, level
    logic gpio;
    // Alert input, level
    logic alert;
  } irq_src_t;

endpackage

/* periph_bus.sv */
// APB decoder for four 4 KiB regions, upper address bits are ignored
// Combinational only, adds no cycle to a transfer
`timescale 1ns/1ps
`include "periph_macros.svh"

module periph_bus (
  input  apb_pkg::apb_req_t  req_i,
  input  apb_pkg::apb_resp_t slv_resp_i [`NUM_SLAVES],
  output apb_pkg::apb_req_t  slv_req_o  [`NUM_SLAVES],
  output apb_pkg::apb_resp_t resp_o
);

  import apb_pkg::*;

  // Incoming address and the index decoded from it
  apb_addr_u                   addr;
  logic [`SLAVE_IDX_WIDTH-1:0] sel_idx;

  assign addr    = req_i.paddr;
  assign sel_idx = addr.fields.slave_idx;

  ////////////////////////////////////////////////////////////////////////////
  // Request fan-out
  ////////////////////////////////////////////////////////////////////////////

  // Every slave sees the whole request
  // Only the addressed one gets psel
  always_comb begin
    for (int i = 0; i < `NUM_SLAVES; i++) begin
      slv_req_o[i]      = req_i;
      slv_req_o[i].psel = req_i.psel && (sel_idx == `SLAVE_IDX_WIDTH'(i));
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Response return
  ////////////////////////////////////////////////////////////////////////////

  // Slave count fills the index range, so no default region
  assign resp_o = slv_resp_i[sel_idx];

endmodule

/* apb_gpio.sv */
// 32-pin GPIO with rising-edge interrupts, no pad configuration
// Inputs pass a two-flop synchronizer, edges shorter than a cycle are lost
`timescale 1ns/1ps
`include "periph_macros.svh"

module apb_gpio (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  apb_pkg::apb_req_t      req_i,
  output apb_pkg::apb_resp_t     resp_o,
  input  periph_pkg::gpio_word_t gpio_i,
  output periph_pkg::gpio_word_t gpio_out_o,
  output periph_pkg::gpio_word_t gpio_dir_o,
  output logic                   irq_o
);

  import apb_pkg::*;
  import periph_pkg::*;

  logic [`REG_OFFSET_WIDTH-1:0] offset;
  logic                         access;
  logic                         wr_en;
  logic                         rd_en;
  logic                         reg_hit;
  apb_data_t                    rdata;

  // Synchronizer stages and edge history
  gpio_word_t sync_q1;
  gpio_word_t sync_q2;
  gpio_word_t prev_q;
  gpio_word_t rise;

  // Software visible state
  gpio_word_t dir_q;
  gpio_word_t out_q;
  gpio_word_t inten_q;
  gpio_word_t status_q;

  assign offset = req_i.paddr.fields.offset;
  assign access = req_i.psel && req_i.penable;
  assign wr_en  = access && req_i.pwrite;
  assign rd_en  = access && !req_i.pwrite;

  // Rising edge on the synchronized value
  assign rise = sync_q2 & ~prev_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_q1  <= '0;
      sync_q2  <= '0;
      prev_q   <= '0;
      dir_q    <= '0;
      out_q    <= '0;
      inten_q  <= '0;
      status_q <= '0;
    end else begin
      sync_q1 <= gpio_i;
      sync_q2 <= sync_q1;
      prev_q  <= sync_q2;
      if (wr_en && offset == `GPIO_REG_DIR) begin
        dir_q <= req_i.pwdata;
      end
      if (wr_en && offset == `GPIO_REG_OUT) begin
        out_q <= req_i.pwdata;
      end
      if (wr_en && offset == `GPIO_REG_INTEN) begin
        inten_q <= req_i.pwdata;
      end
      // Read clears status, a new edge in the same cycle still lands
      if (rd_en && offset == `GPIO_REG_INTSTATUS) begin
        status_q <= rise & inten_q;
      end else begin
        status_q <= status_q | (rise & inten_q);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read mux
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    rdata   = '0;
    reg_hit = 1'b1;
    case (offset)
      `GPIO_REG_DIR:       rdata = dir_q;
      `GPIO_REG_IN:        rdata = sync_q2;
      `GPIO_REG_OUT:       rdata = out_q;
      `GPIO_REG_INTEN:     rdata = inten_q;
      `GPIO_REG_INTSTATUS: rdata = status_q;
      default:             reg_hit = 1'b0;
    endcase
  end

  assign resp_o.prdata  = rdata;
  // Error only in the access cycle of an unmapped offset
  assign resp_o.pslverr = access && !reg_hit;

  assign gpio_dir_o = dir_q;
  assign gpio_out_o = out_q;
  assign irq_o      = |status_q;

endmodule

/* apb_timer.sv */
// 32-bit up-counter, wraps to zero on compare match
// A compare value of N gives a match every N+1 enabled cycles
`timescale 1ns/1ps
`include "periph_macros.svh"

module apb_timer (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  apb_pkg::apb_req_t  req_i,
  output apb_pkg::apb_resp_t resp_o,
  output logic               match_o
);

  import apb_pkg::*;

  logic [`REG_OFFSET_WIDTH-1:0] offset;
  logic                         access;
  logic                         wr_en;
  logic                         reg_hit;
  logic                         cmp_hit;
  apb_data_t                    rdata;

  logic      enable_q;
  apb_data_t count_q;
  apb_data_t cmp_q;

  assign offset  = req_i.paddr.fields.offset;
  assign access  = req_i.psel && req_i.penable;
  assign wr_en   = access && req_i.pwrite;
  assign cmp_hit = (count_q == cmp_q);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      enable_q <= 1'b0;
      count_q  <= '0;
      cmp_q    <= '0;
      match_o  <= 1'b0;
    end else begin
      // Registered pulse, one cycle per match
      match_o <= enable_q && cmp_hit;
      if (wr_en && offset == `TIMER_REG_CTRL) begin
        enable_q <= req_i.pwdata[0];
      end
      if (wr_en && offset == `TIMER_REG_CMP) begin
        cmp_q <= req_i.pwdata;
      end
      // Software write wins over counting
      if (wr_en && offset == `TIMER_REG_COUNT) begin
        count_q <= req_i.pwdata;
      end else if (enable_q) begin
        count_q <= cmp_hit ? '0 : count_q + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read mux
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    rdata   = '0;
    reg_hit = 1'b1;
    case (offset)
      `TIMER_REG_CTRL:  rdata[0] = enable_q;
      `TIMER_REG_COUNT: rdata    = count_q;
      `TIMER_REG_CMP:   rdata    = cmp_q;
      default:          reg_hit  = 1'b0;
    endcase
  end

  assign resp_o.prdata  = rdata;
  assign resp_o.pslverr = access && !reg_hit;

endmodule

/* apb_event_unit.sv */
// Interrupt pending and enable registers, no core sleep control
// Sources are sampled every cycle, a live source beats a clear write
`timescale 1ns/1ps
`include "periph_macros.svh"

module apb_event_unit (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  apb_pkg::apb_req_t    req_i,
  output apb_pkg::apb_resp_t   resp_o,
  input  periph_pkg::irq_src_t src_i,
  output periph_pkg::irq_vec_t irq_o
);

  import apb_pkg::*;
  import periph_pkg::*;

  logic [`REG_OFFSET_WIDTH-1:0] offset;
  logic                         access;
  logic                         wr_en;
  logic                         reg_hit;
  apb_data_t                    rdata;

  irq_vec_t src_vec;
  irq_vec_t clr_vec;
  irq_vec_t ier_q;
  irq_vec_t ipr_q;

  assign offset = req_i.paddr.fields.offset;
  assign access = req_i.psel && req_i.penable;
  assign wr_en  = access && req_i.pwrite;

  // Sources into their vector positions
  // Reserved fields stay zero
  always_comb begin
    src_vec              = '0;
    src_vec.timer_evt[0] = src_i.timer;
    src_vec.gpio_evt     = src_i.gpio;
    src_vec.alert_evt    = src_i.alert;
  end

  // Write-one-to-clear mask, only in the ICP access cycle
  assign clr_vec = (wr_en && offset == `EVENT_REG_ICP) ? irq_vec_t'(req_i.pwdata) : '0;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ier_q <= '0;
      ipr_q <= '0;
    end else begin
      if (wr_en && offset == `EVENT_REG_IER) begin
        ier_q <= irq_vec_t'(req_i.pwdata);
      end
      ipr_q <= irq_vec_t'((ipr_q & ~clr_vec) | src_vec);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read mux
  ////////////////////////////////////////////////////////////////////////////

  // ICP reads back as zero
  always_comb begin
    rdata   = '0;
    reg_hit = 1'b1;
    case (offset)
      `EVENT_REG_IER: rdata   = ier_q;
      `EVENT_REG_IPR: rdata   = ipr_q;
      `EVENT_REG_ICP: rdata   = '0;
      default:        reg_hit = 1'b0;
    endcase
  end

  assign resp_o.prdata  = rdata;
  assign resp_o.pslverr = access && !reg_hit;

  // Pending to irq path has no register
  assign irq_o = irq_vec_t'(ipr_q & ier_q);

endmodule

/* apb_soc_ctrl.sv */
// SoC control with pad-mux word and boot address only
// Boot address leaves reset at the ROM start
`timescale 1ns/1ps
`include "periph_macros.svh"

module apb_soc_ctrl (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  apb_pkg::apb_req_t  req_i,
  output apb_pkg::apb_resp_t resp_o,
  output apb_pkg::apb_data_t pad_mux_o,
  output apb_pkg::apb_data_t boot_addr_o
);

  import apb_pkg::*;

  logic [`REG_OFFSET_WIDTH-1:0] offset;
  logic                         access;
  logic                         wr_en;
  logic                         reg_hit;
  apb_data_t                    rdata;

  apb_data_t pad_mux_q;
  apb_data_t boot_addr_q;

  assign offset = req_i.paddr.fields.offset;
  assign access = req_i.psel && req_i.penable;
  assign wr_en  = access && req_i.pwrite;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pad_mux_q   <= '0;
      boot_addr_q <= `ROM_START_ADDR;
    end else begin
      if (wr_en && offset == `SOC_REG_PADMUX) begin
        pad_mux_q <= req_i.pwdata;
      end
      if (wr_en && offset == `SOC_REG_BOOTADR) begin
        boot_addr_q <= req_i.pwdata;
      end
    end
  end

  // Read back and unmapped offsets
  always_comb begin
    rdata   = '0;
    reg_hit = 1'b1;
    case (offset)
      `SOC_REG_PADMUX:  rdata   = pad_mux_q;
      `SOC_REG_BOOTADR: rdata   = boot_addr_q;
      default:          reg_hit = 1'b0;
    endcase
  end

  assign resp_o.prdata  = rdata;
  assign resp_o.pslverr = access && !reg_hit;

  assign pad_mux_o   = pad_mux_q;
  assign boot_addr_o = boot_addr_q;

endmodule

/* peripherals.sv */
// APB peripheral subsystem with GPIO, timer, event unit and SoC control
// Single clock domain, plain APB slave port without wait states
`timescale 1ns/1ps
`include "periph_macros.svh"

module peripherals (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  apb_pkg::apb_req_t      apb_req_i,
  output apb_pkg::apb_resp_t     apb_resp_o,
  input  periph_pkg::gpio_word_t gpio_i,
  output periph_pkg::gpio_word_t gpio_out_o,
  output periph_pkg::gpio_word_t gpio_dir_o,
  input  logic                   tmr_err_i,
  output periph_pkg::irq_vec_t   irq_o,
  output apb_pkg::apb_data_t     pad_mux_o,
  output apb_pkg::apb_data_t     boot_addr_o
);

  import apb_pkg::*;
  import periph_pkg::*;

  // Per-slave request and response
  apb_req_t  slv_req  [`NUM_SLAVES];
  apb_resp_t slv_resp [`NUM_SLAVES];

  logic     timer_match;
  logic     gpio_irq;
  irq_src_t irq_src;

  // Event sources, alert passes straight through
  assign irq_src.timer = timer_match;
  assign irq_src.gpio  = gpio_irq;
  assign irq_src.alert = tmr_err_i;

  ////////////////////////////////////////////////////////////////////////////
  // Decoder
  ////////////////////////////////////////////////////////////////////////////

  periph_bus periph_bus_i (
    .req_i      ( apb_req_i  ),
    .slv_resp_i ( slv_resp   ),
    .slv_req_o  ( slv_req    ),
    .resp_o     ( apb_resp_o )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Slaves
  ////////////////////////////////////////////////////////////////////////////

  apb_gpio apb_gpio_i (
    .clk_i      ( clk_i                ),
    .rst_n_i    ( rst_n_i              ),
    .req_i      ( slv_req[`SLAVE_GPIO]  ),
    .resp_o     ( slv_resp[`SLAVE_GPIO] ),
    .gpio_i     ( gpio_i               ),
    .gpio_out_o ( gpio_out_o           ),
    .gpio_dir_o ( gpio_dir_o           ),
    .irq_o      ( gpio_irq             )
  );

  apb_timer apb_timer_i (
    .clk_i   ( clk_i                  ),
    .rst_n_i ( rst_n_i                ),
    .req_i   ( slv_req[`SLAVE_TIMER]  ),
    .resp_o  ( slv_resp[`SLAVE_TIMER] ),
    .match_o ( timer_match            )
  );

  apb_event_unit apb_event_unit_i (
    .clk_i   ( clk_i                  ),
    .rst_n_i ( rst_n_i                ),
    .req_i   ( slv_req[`SLAVE_EVENT]  ),
    .resp_o  ( slv_resp[`SLAVE_EVENT] ),
    .src_i   ( irq_src                ),
    .irq_o   ( irq_o                  )
  );

  apb_soc_ctrl apb_soc_ctrl_i (
    .clk_i       ( clk_i                ),
    .rst_n_i     ( rst_n_i              ),
    .req_i       ( slv_req[`SLAVE_SOC]  ),
    .resp_o      ( slv_resp[`SLAVE_SOC] ),
    .pad_mux_o   ( pad_mux_o            ),
    .boot_addr_o ( boot_addr_o          )
  );

endmodule

/* peripherals_assert.sv */
// Protocol and interrupt checks for the peripheral top level, attached by bind
// Sampled on the rising clock edge and off while reset is low
`timescale 1ns/1ps
`include "periph_macros.svh"

module peripherals_assert (
  input logic                 clk_i,
  input logic                 rst_n_i,
  input apb_pkg::apb_req_t    apb_req_i,
  input apb_pkg::apb_resp_t   apb_resp_i,
  input periph_pkg::irq_vec_t irq_i
);

  import apb_pkg::*;
  import periph_pkg::*;

  // Number of failed assertions so far
  int   fail_count = 0;
  logic rsvd_any;

  // Any bit without a source
  assign rsvd_any = |{irq_i.timer_evt[3:1], irq_i.rsvd_27_26, irq_i.rsvd_24_23, irq_i.rsvd_low};

  // Access phase needs a selected slave
  penable_needs_psel: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    apb_req_i.penable |-> apb_req_i.psel
  ) else begin
    $error("penable high without psel");
    fail_count = fail_count + 1;
  end

  // Error response only inside an access cycle
  slverr_in_access: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    apb_resp_i.pslverr |-> (apb_req_i.psel && apb_req_i.penable)
  ) else begin
    $error("pslverr outside an access cycle");
    fail_count = fail_count + 1;
  end

  rsvd_irq_zero: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !rsvd_any
  ) else begin
    $error("reserved irq bit set");
    fail_count = fail_count + 1;
  end

endmodule

// Checks follow every instance of the top level
bind peripherals peripherals_assert peripherals_assert_i (
  .clk_i      ( clk_i      ),
  .rst_n_i    ( rst_n_i    ),
  .apb_req_i  ( apb_req_i  ),
  .apb_resp_i ( apb_resp_o ),
  .irq_i      ( irq_o      )
);

/* tb_peripherals.sv */
// Directed testbench for the APB peripheral subsystem that stops at the first wrong value
// Interrupt timing checks rely on one idle cycle between transfers
`timescale 1ns/1ps
`include "periph_macros.svh"

module tb_peripherals;

  import apb_pkg::*;
  import periph_pkg::*;

  localparam int CLK_PERIOD      = 4;
  localparam int NUM_TESTS       = 5;
  localparam int CYCLES_PER_TEST = 200;
  localparam int UPPER_W         = `APB_ADDR_WIDTH - `SLAVE_IDX_WIDTH - `REG_OFFSET_WIDTH;

  // Offset that no slave decodes
  localparam logic [`REG_OFFSET_WIDTH-1:0] UNMAPPED_OFFSET = 12'h100;

  // Numerical Recipes LCG constants
  localparam logic [31:0] LCG_SEED = 32'h759a_45d8;
  localparam logic [31:0] LCG_MUL  = 32'd1664525;
  localparam logic [31:0] LCG_INC  = 32'd1013904223;

  // Interrupt vector bits in the legacy layout
  localparam logic [31:0] IRQ_TIMER = 32'h1000_0000;
  localparam logic [31:0] IRQ_GPIO  = 32'h0200_0000;
  localparam logic [31:0] IRQ_ALERT = 32'h0040_0000;

  logic       clk;
  logic       rst_n;
  apb_req_t   apb_req;
  apb_resp_t  apb_resp;
  gpio_word_t gpio_in;
  gpio_word_t gpio_out;
  gpio_word_t gpio_dir;
  logic       tmr_err;
  irq_vec_t   irq;
  apb_data_t  pad_mux;
  apb_data_t  boot_addr;

  // Register contents the tests expect after their own writes
  apb_data_t  pad_mux_exp;
  apb_data_t  boot_addr_exp;
  gpio_word_t dir_exp;
  gpio_word_t out_exp;

  logic [31:0] lcg_state = LCG_SEED;

  peripherals uut (
    .clk_i       ( clk       ),
    .rst_n_i     ( rst_n     ),
    .apb_req_i   ( apb_req   ),
    .apb_resp_o  ( apb_resp  ),
    .gpio_i      ( gpio_in   ),
    .gpio_out_o  ( gpio_out  ),
    .gpio_dir_o  ( gpio_dir  ),
    .tmr_err_i   ( tmr_err   ),
    .irq_o       ( irq       ),
    .pad_mux_o   ( pad_mux   ),
    .boot_addr_o ( boot_addr )
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * LCG_MUL + LCG_INC;
    return lcg_state;
  endfunction

  // Build an address from the field view of the union
  function automatic apb_addr_u make_addr(input int unsigned slave,
                                          input logic [`REG_OFFSET_WIDTH-1:0] offset,
                                          input logic [UPPER_W-1:0] upper);
    apb_addr_u addr;
    addr.fields.upper     = upper;
    addr.fields.slave_idx = slave[`SLAVE_IDX_WIDTH-1:0];
    addr.fields.offset    = offset;
    return addr;
  endfunction

  task automatic check_data(input apb_data_t got, input apb_data_t exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s, got %h, expected %h", $time, what, got, exp);
      $display("ERRORS FOUND");
      $fatal(1);
    end
  endtask

  task automatic check_err(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s, got %b, expected %b", $time, what, got, exp);
      $display("ERRORS FOUND");
      $fatal(1);
    end
  endtask

  task automatic check_gpio(input gpio_word_t got, input gpio_word_t exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s, got %h, expected %h", $time, what, got, exp);
      $display("ERRORS FOUND");
      $fatal(1);
    end
  endtask

  task automatic check_irq(input irq_vec_t got, input irq_vec_t exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s, got %h, expected %h", $time, what, got, exp);
      $display("ERRORS FOUND");
      $fatal(1);
    end
  endtask

  // Setup and access cycle with the write landing on the edge that ends the access
  task automatic apb_write(input apb_addr_u addr, input apb_data_t data, input logic exp_err);
    apb_req_t req;
    req        = '0;
    req.paddr  = addr;
    req.pwdata = data;
    req.pwrite = 1'b1;
    req.psel   = 1'b1;
    @(posedge clk);
    apb_req <= req;
    req.penable = 1'b1;
    @(posedge clk);
    apb_req <= req;
    // Response is stable mid access cycle
    @(negedge clk);
    check_err(apb_resp.pslverr, exp_err, $sformatf("pslverr on write to %h", addr.word));
    @(posedge clk);
    apb_req <= '0;
  endtask

  task automatic apb_read(input apb_addr_u addr, input logic exp_err, output apb_data_t data);
    apb_req_t req;
    req       = '0;
    req.paddr = addr;
    req.psel  = 1'b1;
    @(posedge clk);
    apb_req <= req;
    req.penable = 1'b1;
    @(posedge clk);
    apb_req <= req;
    @(negedge clk);
    data = apb_resp.prdata;
    check_err(apb_resp.pslverr, exp_err, $sformatf("pslverr on read of %h", addr.word));
    @(posedge clk);
    apb_req <= '0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic reset_and_soc_ctrl();
    apb_data_t w;
    apb_data_t r;
    pad_mux_exp   = '0;
    boot_addr_exp = `ROM_START_ADDR;
    dir_exp       = '0;
    out_exp       = '0;
    check_data(boot_addr, boot_addr_exp, "boot address after reset");
    check_data(pad_mux, pad_mux_exp, "pad mux after reset");
    check_irq(irq, '0, "irq after reset");
    check_gpio(gpio_out, out_exp, "gpio out after reset");
    check_gpio(gpio_dir, dir_exp, "gpio dir after reset");
    w = next_random();
    pad_mux_exp = w;
    apb_write(make_addr(`SLAVE_SOC, `SOC_REG_PADMUX, '0), w, 1'b0);
    @(negedge clk);
    check_data(pad_mux, pad_mux_exp, "pad mux port");
    apb_read(make_addr(`SLAVE_SOC, `SOC_REG_PADMUX, '0), 1'b0, r);
    check_data(r, pad_mux_exp, "PADMUX read back");
    w = next_random();
    boot_addr_exp = w;
    apb_write(make_addr(`SLAVE_SOC, `SOC_REG_BOOTADR, '0), w, 1'b0);
    @(negedge clk);
    check_data(boot_addr, boot_addr_exp, "boot address port");
    apb_read(make_addr(`SLAVE_SOC, `SOC_REG_BOOTADR, '0), 1'b0, r);
    check_data(r, boot_addr_exp, "BOOTADR read back");
  endtask

  task automatic gpio_data_path();
    apb_data_t  w;
    apb_data_t  r;
    gpio_word_t pattern;
    w = next_random();
    dir_exp = w;
    apb_write(make_addr(`SLAVE_GPIO, `GPIO_REG_DIR, '0), w, 1'b0);
    @(negedge clk);
    check_gpio(gpio_dir, dir_exp, "gpio dir port");
    apb_read(make_addr(`SLAVE_GPIO, `GPIO_REG_DIR, '0), 1'b0, r);
    check_data(r, dir_exp, "DIR read back");
    w = next_random();
    out_exp = w;
    apb_write(make_addr(`SLAVE_GPIO, `GPIO_REG_OUT, '0), w, 1'b0);
    @(negedge clk);
    check_gpio(gpio_out, out_exp, "gpio out port");
    apb_read(make_addr(`SLAVE_GPIO, `GPIO_REG_OUT, '0), 1'b0, r);
    check_data(r, out_exp, "OUT read back");
    // Input passes two synchronizer flops
    pattern = next_random();
    @(posedge clk);
    gpio_in <= pattern;
    repeat (2) @(posedge clk);
    apb_read(make_addr(`SLAVE_GPIO, `GPIO_REG_IN, '0), 1'b0, r);
    check_data(r, pattern, "IN after synchronizer");
  endtask

  task automatic address_decoding();
    apb_data_t          r;
    apb_data_t          w;
    logic [UPPER_W-1:0] upper;
    for (int s = 0; s < `NUM_SLAVES; s++) begin
      apb_read(make_addr(s, UNMAPPED_OFFSET, '0), 1'b1, r);
      check_data(r, '0, $sformatf("unmapped read data in region %0d", s));
      apb_write(make_addr(s, UNMAPPED_OFFSET, '0), next_random(), 1'b1);
    end
    @(negedge clk);
    check_data(pad_mux, pad_mux_exp, "pad mux after unmapped writes");
    check_data(boot_addr, boot_addr_exp, "boot address after unmapped writes");
    check_gpio(gpio_dir, dir_exp, "gpio dir after unmapped writes");
    check_gpio(gpio_out, out_exp, "gpio out after unmapped writes");
    // Timer and event unit still hold their reset values
    apb_read(make_addr(`SLAVE_TIMER, `TIMER_REG_CTRL, '0), 1'b0, r);
    check_data(r, '0, "timer CTRL after unmapped writes");
    apb_read(make_addr(`SLAVE_TIMER, `TIMER_REG_CMP, '0), 1'b0, r);
    check_data(r, '0, "timer CMP after unmapped writes");
    apb_read(make_addr(`SLAVE_EVENT, `EVENT_REG_IER, '0), 1'b0, r);
    check_data(r, '0, "IER after unmapped writes");
    // Nonzero upper bits alias onto the same register
    w     = next_random();
    upper = w[UPPER_W-1:0];
    upper[0] = 1'b1;
    w = next_random();
    pad_mux_exp = w;
    apb_write(make_addr(`SLAVE_SOC, `SOC_REG_PADMUX, upper), w, 1'b0);
    apb_read(make_addr(`SLAVE_SOC, `SOC_REG_PADMUX, '0), 1'b0, r);
    check_data(r, pad_mux_exp, "PADMUX written through alias");
    apb_read(make_addr(`SLAVE_GPIO, `GPIO_REG_OUT, upper), 1'b0, r);
    check_data(r, out_exp, "OUT read through alias");
  endtask

  task automatic timer_match_irq();
    apb_data_t w;
    int        n;
    w = next_random();
    n = 4 + int'(w[3:0]);
    apb_write(make_addr(`SLAVE_TIMER, `TIMER_REG_CMP, '0), apb_data_t'(n), 1'b0);
    apb_write(make_addr(`SLAVE_TIMER, `TIMER_REG_COUNT, '0), '0, 1'b0);
    apb_write(make_addr(`SLAVE_EVENT, `EVENT_REG_IER, '0), IRQ_TIMER, 1'b0);
    apb_write(make_addr(`SLAVE_TIMER, `TIMER_REG_CTRL, '0), 32'h1, 1'b0);
    // Count reaches N before the pulse sets pending
    repeat (n) @(posedge clk);
    @(negedge clk);
    check_irq(irq, '0, $sformatf("timer irq %0d cycles after enable", n));
    repeat (3) @(posedge clk);
    @(negedge clk);
    check_irq(irq, irq_vec_t'(IRQ_TIMER), $sformatf("timer irq %0d cycles after enable", n + 3));
    apb_write(make_addr(`SLAVE_TIMER, `TIMER_REG_CTRL, '0), '0, 1'b0);
    apb_write(make_addr(`SLAVE_EVENT, `EVENT_REG_ICP, '0), IRQ_TIMER, 1'b0);
    @(negedge clk);
    check_irq(irq, '0, "timer irq after clear");
  endtask

  task automatic gpio_irq_and_alert();
    apb_data_t  w;
    apb_data_t  r;
    gpio_word_t mask;
    // Flush old input history through the synchronizer
    @(posedge clk);
    gpio_in <= '0;
    repeat (3) @(posedge clk);
    w    = next_random();
    mask = gpio_word_t'(1) << w[4:0];
    apb_write(make_addr(`SLAVE_GPIO, `GPIO_REG_INTEN, '0), mask, 1'b0);
    apb_write(make_addr(`SLAVE_EVENT, `EVENT_REG_IER, '0), IRQ_GPIO, 1'b0);
    @(posedge clk);
    gpio_in <= mask;
    repeat (3) @(posedge clk);
    @(negedge clk);
    check_irq(irq, '0, "gpio irq 3 cycles after edge");
    @(posedge clk);
    @(negedge clk);
    check_irq(irq, irq_vec_t'(IRQ_GPIO), "gpio irq 4 cycles after edge");
    apb_read(make_addr(`SLAVE_GPIO, `GPIO_REG_INTSTATUS, '0), 1'b0, r);
    check_data(r, mask, "INTSTATUS pin mask");
    apb_read(make_addr(`SLAVE_GPIO, `GPIO_REG_INTSTATUS, '0), 1'b0, r);
    check_data(r, '0, "INTSTATUS after read clear");
    apb_write(make_addr(`SLAVE_EVENT, `EVENT_REG_ICP, '0), IRQ_GPIO, 1'b0);
    @(negedge clk);
    check_irq(irq, '0, "gpio irq after clear");
    repeat (4) @(posedge clk);
    @(negedge clk);
    check_irq(irq, '0, "gpio irq stays low");
    // Alert pends but stays masked until enabled
    @(posedge clk);
    tmr_err <= 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_irq(irq, '0, "masked alert");
    apb_read(make_addr(`SLAVE_EVENT, `EVENT_REG_IPR, '0), 1'b0, r);
    check_data(r, IRQ_ALERT, "IPR with alert pending");
    apb_write(make_addr(`SLAVE_EVENT, `EVENT_REG_IER, '0), IRQ_ALERT | IRQ_GPIO, 1'b0);
    @(negedge clk);
    check_irq(irq, irq_vec_t'(IRQ_ALERT), "enabled alert");
    @(posedge clk);
    tmr_err <= 1'b0;
    apb_write(make_addr(`SLAVE_EVENT, `EVENT_REG_ICP, '0), IRQ_ALERT, 1'b0);
    @(negedge clk);
    check_irq(irq, '0, "alert after clear");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    apb_req = '0;
    gpio_in = '0;
    tmr_err = 1'b0;
    rst_n   = 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    reset_and_soc_ctrl();
    gpio_data_path();
    address_decoding();
    timer_match_irq();
    gpio_irq_and_alert();
    repeat (2) @(posedge clk);
    // Bound checker counts its own failures
    if (uut.peripherals_assert_i.fail_count == 0) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      $display("Protocol assertions failed during the run");
      $display("ERRORS FOUND");
      $fatal(1);
    end
  end

  initial begin
    repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clk);
    $display("Timeout, tests did not finish within %0d cycles", NUM_TESTS * CYCLES_PER_TEST);
    $display("ERRORS FOUND");
    $fatal(1);
  end

endmodule

/* project.f */
+incdir+.
apb_pkg.sv
periph_pkg.sv
periph_bus.sv
apb_gpio.sv
apb_timer.sv
apb_event_unit.sv
apb_soc_ctrl.sv
peripherals.sv
peripherals_assert.sv
tb_peripherals.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_peripherals
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= NO ERRORS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
